// File: files.f
+incdir+hdl
hdl/icache_pkg.sv
hdl/icache_lines.sv
hdl/icache_memctrl.sv
hdl/icache_fetcher.sv
hdl/icache_top.sv
verification/icache_tb.sv

// File: hdl/icache_defines.svh
////////////////////////////////////////////////////////////////////////////
// Cache geometry. A line must hold a whole number of memory beats, and
// the depth and the line size in bytes must both be powers of two
////////////////////////////////////////////////////////////////////////////

`ifndef ICACHE_DEFINES_SVH
`define ICACHE_DEFINES_SVH

// Instruction word returned to the fetch stage
`define ICACHE_XLEN 32

// Byte address on the fetch and memory channels
`define ICACHE_ADDR_W 32

// Request ID carried from AR to R on the fetch side
`define ICACHE_ID_W 4

// One beat of the memory read data channel
`define ICACHE_MEM_DATA_W 32

// Payload bits per cache line, tag and valid not included
`define ICACHE_LINE_W 128

// Number of lines, direct mapped
`define ICACHE_DEPTH 64

// Beats needed to fill one line
`define ICACHE_BEATS (`ICACHE_LINE_W / `ICACHE_MEM_DATA_W)

`endif

// File: hdl/icache_fetcher.sv
////////////////////////////////////////////////////////////////////////////
// One fetch in flight. flush_req must stay high until flush_ack is seen,
// and a fetch pending beside a flush waits for the flush to end
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module icache_fetcher (
    input  logic              aclk,
    input  logic              rst_n,
    input  logic              flush_req,
    output logic              flush_ack,
    input  logic              ctrl_arvalid,
    output logic              ctrl_arready,
    input  icache_pkg::addr_t ctrl_araddr,
    input  icache_pkg::id_t   ctrl_arid,
    output logic              ctrl_rvalid,
    input  logic              ctrl_rready,
    output icache_pkg::id_t   ctrl_rid,
    output icache_pkg::word_t ctrl_rdata,
    output logic              lookup_en,
    output icache_pkg::addr_t lookup_addr,
    input  icache_pkg::word_t lookup_word,
    input  logic              lookup_hit,
    input  logic              lookup_miss,
    output logic              clear_all,
    output logic              fill_valid,
    input  logic              fill_ready,
    output icache_pkg::addr_t fill_addr,
    input  logic              fill_done
);

    import icache_pkg::*;

    fetch_state_t state;
    // Second cycle of LOOKUP, where the line store result is present
    logic         lookup_pend;
    // Flush steps: 0 clear, 1 acknowledge, 2 wait for release
    logic [1:0]   flush_step;
    // Keeps the fetch port closed in the first cycle after reset
    logic         init_done;

    // Captured request and returned word
    addr_t req_addr;
    id_t   req_id;
    word_t resp_data;

    ////////////////////////////////////////////////////////////////////////////
    // Outputs
    ////////////////////////////////////////////////////////////////////////////

    // A waiting flush takes priority over a new fetch
    assign ctrl_arready = init_done && (state == FETCH_IDLE) && !flush_req;
    assign ctrl_rvalid  = (state == FETCH_RESPOND);
    assign ctrl_rid     = req_id;
    assign ctrl_rdata   = resp_data;

    // Lookup issued in the first LOOKUP cycle, also for the re-lookup after a fill
    assign lookup_en    = (state == FETCH_LOOKUP) && !lookup_pend;
    assign lookup_addr  = req_addr;
    assign fill_addr    = req_addr;
    assign clear_all    = (state == FETCH_FLUSH) && (flush_step == 2'd0);

    ////////////////////////////////////////////////////////////////////////////
    // Fetch FSM
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= FETCH_IDLE;
            lookup_pend <= 1'b0;
            flush_step  <= 2'd0;
            init_done   <= 1'b0;
            fill_valid  <= 1'b0;
            flush_ack   <= 1'b0;
        end else begin
            init_done <= 1'b1;
            flush_ack <= 1'b0;
            case (state)
                FETCH_IDLE: begin
                    if (init_done && flush_req) begin
                        state <= FETCH_FLUSH;
                    end else if (ctrl_arvalid && ctrl_arready) begin
                        state <= FETCH_LOOKUP;
                    end
                end
                FETCH_LOOKUP: begin
                    if (!lookup_pend) begin
                        lookup_pend <= 1'b1;
                    end else begin
                        lookup_pend <= 1'b0;
                        if (lookup_hit) begin
                            state <= FETCH_RESPOND;
                        end else if (lookup_miss) begin
                            // Hand the address to the memory controller
                            fill_valid <= 1'b1;
                            state      <= FETCH_MISS_WAIT;
                        end
                    end
                end
                FETCH_MISS_WAIT: begin
                    if (fill_valid && fill_ready) begin
                        fill_valid <= 1'b0;
                    end
                    // Line is written now, look it up again
                    if (fill_done) begin
                        state <= FETCH_LOOKUP;
                    end
                end
                FETCH_RESPOND: begin
                    // Response held stable under back-pressure
                    if (ctrl_rready) begin
                        state <= FETCH_IDLE;
                    end
                end
                FETCH_FLUSH: begin
                    case (flush_step)
                        2'd0: flush_step <= 2'd1;
                        2'd1: begin
                            flush_ack  <= 1'b1;
                            flush_step <= 2'd2;
                        end
                        default: begin
                            if (!flush_req) begin
                                flush_step <= 2'd0;
                                state      <= FETCH_IDLE;
                            end
                        end
                    endcase
                end
                default: state <= FETCH_IDLE;
            endcase
        end
    end

    // Request and response payload
    always_ff @(posedge aclk) begin
        if (ctrl_arvalid && ctrl_arready) begin
            req_addr <= ctrl_araddr;
            req_id   <= ctrl_arid;
        end
        if ((state == FETCH_LOOKUP) && lookup_pend && lookup_hit) begin
            resp_data <= lookup_word;
        end
    end

endmodule

`default_nettype wire

// File: hdl/icache_lines.sv
////////////////////////////////////////////////////////////////////////////
// Direct-mapped store. Result is one cycle after lookup_en; a read and a
// write to the same line in one cycle returns the old content
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "icache_defines.svh"

module icache_lines (
    input  logic              aclk,
    input  logic              rst_n,
    input  logic              clear_all,
    input  logic              lookup_en,
    input  icache_pkg::addr_t lookup_addr,
    output icache_pkg::word_t lookup_word,
    output logic              lookup_hit,
    output logic              lookup_miss,
    input  logic              line_wen,
    input  icache_pkg::addr_t line_waddr,
    input  icache_pkg::line_t line_wdata
);

    import icache_pkg::*;

    // Address split: | tag | index | word select | byte |
    localparam int OFF_W  = $clog2(`ICACHE_LINE_W / 8);
    localparam int IDX_W  = $bits(index_t);
    localparam int TAG_W  = $bits(tag_t);
    localparam int BYTE_W = $clog2(`ICACHE_XLEN / 8);
    localparam int WSEL_W = $clog2(`ICACHE_LINE_W / `ICACHE_XLEN);

    // Storage arrays
    line_t                    data_mem [`ICACHE_DEPTH];
    tag_t                     tag_mem  [`ICACHE_DEPTH];
    logic [`ICACHE_DEPTH-1:0] valid;

    // Decoded read and write addresses
    index_t            rd_idx;
    index_t            wr_idx;
    tag_t              rd_tag;
    tag_t              wr_tag;
    logic [WSEL_W-1:0] rd_wsel;

    // Registered read result
    word_t rd_word;
    logic  rd_match;
    logic  rd_pend;

    assign rd_idx  = lookup_addr[OFF_W +: IDX_W];
    assign rd_tag  = lookup_addr[`ICACHE_ADDR_W-1 -: TAG_W];
    assign rd_wsel = lookup_addr[BYTE_W +: WSEL_W];
    assign wr_idx  = line_waddr[OFF_W +: IDX_W];
    assign wr_tag  = line_waddr[`ICACHE_ADDR_W-1 -: TAG_W];

    // Valid bits, cleared at once by a flush
    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            valid   <= '0;
            rd_pend <= 1'b0;
        end else begin
            rd_pend <= lookup_en;
            if (clear_all) begin
                valid <= '0;
            end else if (line_wen) begin
                valid[wr_idx] <= 1'b1;
            end
        end
    end

    // Line and tag write from the memory controller
    always_ff @(posedge aclk) begin
        if (line_wen) begin
            data_mem[wr_idx] <= line_wdata;
            tag_mem[wr_idx]  <= wr_tag;
        end
    end

    // Word select and tag compare, both registered
    always_ff @(posedge aclk) begin
        if (lookup_en) begin
            rd_word  <= data_mem[rd_idx][rd_wsel*`ICACHE_XLEN +: `ICACHE_XLEN];
            rd_match <= valid[rd_idx] && (tag_mem[rd_idx] == rd_tag);
        end
    end

    // Exactly one of hit or miss, only in the result cycle
    assign lookup_word = rd_word;
    assign lookup_hit  = rd_pend & rd_match;
    assign lookup_miss = rd_pend & ~rd_match;

endmodule

`default_nettype wire

// File: hdl/icache_memctrl.sv
////////////////////////////////////////////////////////////////////////////
// One INCR burst per miss, one miss at a time. The memory must end the
// burst with rlast on exactly ICACHE_BEATS beats; response codes are ignored
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "icache_defines.svh"

module icache_memctrl (
    input  logic                   aclk,
    input  logic                   rst_n,
    input  logic                   fill_valid,
    output logic                   fill_ready,
    input  icache_pkg::addr_t      fill_addr,
    output logic                   fill_done,
    output logic                   mem_arvalid,
    input  logic                   mem_arready,
    output icache_pkg::addr_t      mem_araddr,
    output icache_pkg::burst_len_t mem_arlen,
    input  logic                   mem_rvalid,
    output logic                   mem_rready,
    input  icache_pkg::mem_data_t  mem_rdata,
    input  logic                   mem_rlast,
    output logic                   line_wen,
    output icache_pkg::addr_t      line_waddr,
    output icache_pkg::line_t      line_wdata
);

    import icache_pkg::*;

    // Low address bits that select a byte inside a line
    localparam addr_t LINE_MASK = addr_t'(`ICACHE_LINE_W / 8 - 1);

    fill_state_t state;
    // Line-aligned miss address, held for the burst and the line write
    addr_t       line_addr;
    // Beats collect here, first beat ends in the lowest bits
    line_t       line_buf;

    ////////////////////////////////////////////////////////////////////////////
    // Channel outputs
    ////////////////////////////////////////////////////////////////////////////

    // New miss only taken while no burst runs
    assign fill_ready = (state == FILL_IDLE);
    // Never stall the memory once the burst has started
    assign mem_rready = (state == FILL_DATA);
    assign mem_araddr = line_addr;
    assign mem_arlen  = burst_len_t'(`ICACHE_BEATS - 1);
    assign line_waddr = line_addr;
    assign line_wdata = line_buf;

    ////////////////////////////////////////////////////////////////////////////
    // Fill FSM
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= FILL_IDLE;
            mem_arvalid <= 1'b0;
            line_wen    <= 1'b0;
            fill_done   <= 1'b0;
        end else begin
            // Write pulse, then done one cycle later
            line_wen  <= 1'b0;
            fill_done <= line_wen;
            case (state)
                FILL_IDLE: begin
                    if (fill_valid) begin
                        mem_arvalid <= 1'b1;
                        state       <= FILL_ADDR;
                    end
                end
                FILL_ADDR: begin
                    // Address held until the memory takes it
                    if (mem_arready) begin
                        mem_arvalid <= 1'b0;
                        state       <= FILL_DATA;
                    end
                end
                FILL_DATA: begin
                    // Gaps in rvalid simply wait here
                    if (mem_rvalid && mem_rlast) begin
                        line_wen <= 1'b1;
                        state    <= FILL_IDLE;
                    end
                end
                default: state <= FILL_IDLE;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Address and line assembly
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge aclk) begin
        if (fill_valid && fill_ready) begin
            line_addr <= fill_addr & ~LINE_MASK;
        end
        // Shift down, new beat enters at the top
        if (mem_rvalid && mem_rready) begin
            line_buf <= {mem_rdata, line_buf[`ICACHE_LINE_W-1:`ICACHE_MEM_DATA_W]};
        end
    end

endmodule

`default_nettype wire

// File: hdl/icache_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Widths follow icache_defines.svh; tag and index sizes are derived
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "icache_defines.svh"

package icache_pkg;

    // Vector types
    typedef logic [`ICACHE_ADDR_W-1:0]     addr_t;
    typedef logic [`ICACHE_XLEN-1:0]       word_t;
    typedef logic [`ICACHE_ID_W-1:0]       id_t;
    typedef logic [`ICACHE_MEM_DATA_W-1:0] mem_data_t;
    typedef logic [`ICACHE_LINE_W-1:0]     line_t;
    typedef logic [$clog2(`ICACHE_DEPTH)-1:0] index_t;
    // Address bits left over above the index and the byte offset in a line
    typedef logic [`ICACHE_ADDR_W - $clog2(`ICACHE_DEPTH)
                   - $clog2(`ICACHE_LINE_W / 8) - 1:0] tag_t;
    // AXI4 arlen, beats minus one
    typedef logic [7:0] burst_len_t;

    // Fetch sequencer states
    typedef enum logic [2:0] {
        FETCH_IDLE, FETCH_LOOKUP, FETCH_MISS_WAIT, FETCH_RESPOND, FETCH_FLUSH
    } fetch_state_t;

    // Line fill states
    typedef enum logic [1:0] {FILL_IDLE, FILL_ADDR, FILL_DATA} fill_state_t;

endpackage

`default_nettype wire

// File: hdl/icache_top.sv
////////////////////////////////////////////////////////////////////////////
// Instruction cache top. Memory side is AXI4 read with the constant
// sideband fields left out; INCR bursts of word-sized beats are assumed
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module icache_top (
    input  logic                   aclk,
    input  logic                   rst_n,
    // FENCE.i flush handshake
    input  logic                   flush_req,
    output logic                   flush_ack,
    // Fetch channel
    input  logic                   ctrl_arvalid,
    output logic                   ctrl_arready,
    input  icache_pkg::addr_t      ctrl_araddr,
    input  icache_pkg::id_t        ctrl_arid,
    output logic                   ctrl_rvalid,
    input  logic                   ctrl_rready,
    output icache_pkg::id_t        ctrl_rid,
    output icache_pkg::word_t      ctrl_rdata,
    // Central memory, AXI4 read
    output logic                   mem_arvalid,
    input  logic                   mem_arready,
    output icache_pkg::addr_t      mem_araddr,
    output icache_pkg::burst_len_t mem_arlen,
    input  logic                   mem_rvalid,
    output logic                   mem_rready,
    input  icache_pkg::mem_data_t  mem_rdata,
    input  logic                   mem_rlast
);

    import icache_pkg::*;

    // Fetcher to line store
    logic  lookup_en;
    addr_t lookup_addr;
    word_t lookup_word;
    logic  lookup_hit;
    logic  lookup_miss;
    logic  clear_all;

    // Fetcher to memory controller
    logic  fill_valid;
    logic  fill_ready;
    addr_t fill_addr;
    logic  fill_done;

    // Memory controller to line store
    logic  line_wen;
    addr_t line_waddr;
    line_t line_wdata;

    ////////////////////////////////////////////////////////////////////////////
    // Blocks, connected by matching names
    ////////////////////////////////////////////////////////////////////////////

    // Only the fetcher sequences a flush, so its acknowledge goes straight out
    icache_fetcher fetcher (.*);

    icache_lines lines (.*);

    icache_memctrl mem_ctrl (.*);

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the instruction cache testbench with Verilator, runs it and
# decides pass or fail from the simulation log.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

if ! verilator --binary --timing --timescale 1ns/1ps -f files.f \
        --top-module icache_tb -Mdir "$BUILD_DIR" -o icache_sim; then
    echo "Verilator build failed"
    exit 1
fi

"$BUILD_DIR/icache_sim" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"

if [ "$sim_status" -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "NO ERRORS" "$LOG_FILE"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed, see $LOG_FILE"
    exit 1
fi

// File: verification/icache_tb.sv
////////////////////////////////////////////////////////////////////////////
// Cache testbench. Memory word at byte address a is a ^ 32'h5a5a_0000;
// table addresses are word aligned and each entry runs to completion
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "icache_defines.svh"

module icache_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import icache_pkg::*;

    localparam int NUM_TESTS    = 18;
    localparam int HALF_PERIOD  = 20;
    localparam int RESET_CYCLES = 16;

    // One table entry for a fetch or a flush
    typedef struct packed {
        logic  is_flush;
        addr_t addr;
        id_t   id;
        int    stall;
        word_t exp_word;
        int    exp_bursts;
    } test_t;

    test_t tests [NUM_TESTS];

    // DUT ports
    logic       aclk;
    logic       rst_n;
    logic       flush_req;
    logic       flush_ack;
    logic       ctrl_arvalid;
    logic       ctrl_arready;
    addr_t      ctrl_araddr;
    id_t        ctrl_arid;
    logic       ctrl_rvalid;
    logic       ctrl_rready;
    id_t        ctrl_rid;
    word_t      ctrl_rdata;
    logic       mem_arvalid;
    logic       mem_arready;
    addr_t      mem_araddr;
    burst_len_t mem_arlen;
    logic       mem_rvalid;
    logic       mem_rready;
    mem_data_t  mem_rdata;
    logic       mem_rlast;

    // Memory model state
    integer seed;
    int     burst_count;
    logic   ar_fire;
    logic   r_fire;
    logic   r_active;
    int     r_beat;
    addr_t  r_base;
    // Address of the fetch in flight for the burst address check
    addr_t  cur_addr;

    icache_top dut (.*);

    ////////////////////////////////////////////////////////////////////////////
    // Helpers and compare tasks
    ////////////////////////////////////////////////////////////////////////////

    // Memory content rule
    function automatic word_t memory_word(input addr_t a);
        return a ^ 32'h5a5a_0000;
    endfunction

    task automatic stop_on_error(input string line);
        $display("%s", line);
        $display("ERRORS FOUND");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            stop_on_error($sformatf("** Error %s: expected %h, actual %h",
                                    name, expected, actual));
        end
    endtask

    task automatic check_id(input string name, input id_t expected, input id_t actual);
        if (actual !== expected) begin
            stop_on_error($sformatf("** Error %s: expected %h, actual %h",
                                    name, expected, actual));
        end
    endtask

    task automatic check_addr(input string name, input addr_t expected, input addr_t actual);
        if (actual !== expected) begin
            stop_on_error($sformatf("** Error %s: expected %h, actual %h",
                                    name, expected, actual));
        end
    endtask

    task automatic check_len(input string name, input burst_len_t expected,
                             input burst_len_t actual);
        if (actual !== expected) begin
            stop_on_error($sformatf("** Error %s: expected %0d, actual %0d",
                                    name, expected, actual));
        end
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        if (actual != expected) begin
            stop_on_error($sformatf("** Error %s: expected %0d, actual %0d",
                                    name, expected, actual));
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus table
    ////////////////////////////////////////////////////////////////////////////

    task automatic add_fetch(input int idx, input addr_t addr, input id_t id,
                             input int stall, input int bursts);
        tests[idx].is_flush   = 1'b0;
        tests[idx].addr       = addr;
        tests[idx].id         = id;
        tests[idx].stall      = stall;
        tests[idx].exp_word   = memory_word(addr);
        tests[idx].exp_bursts = bursts;
    endtask

    task automatic add_flush(input int idx);
        tests[idx]          = '0;
        tests[idx].is_flush = 1'b1;
    endtask

    task automatic load_table();
        // Cold miss followed by hits on the rest of the line
        add_fetch(0, 32'h0000_1000, 4'd1, 0, 1);
        add_fetch(1, 32'h0000_1004, 4'd2, 0, 0);
        add_fetch(2, 32'h0000_1008, 4'd3, 2, 0);
        add_fetch(3, 32'h0000_100c, 4'd4, 0, 0);
        // Index 0 with two tags that evict each other
        add_fetch(4, 32'h0000_2004, 4'd5, 0, 1);
        add_fetch(5, 32'h0000_1008, 4'd6, 1, 1);
        add_fetch(6, 32'h0000_200c, 4'd7, 0, 1);
        add_fetch(7, 32'h0000_1000, 4'd8, 3, 1);
        // A second index
        add_fetch(8, 32'h0000_3a58, 4'd9, 0, 1);
        add_fetch(9, 32'h0000_3a5c, 4'd10, 1, 0);
        add_flush(10);
        // Both lines refetched after the flush
        add_fetch(11, 32'h0000_1004, 4'd11, 0, 1);
        add_fetch(12, 32'h0000_3a54, 4'd12, 4, 1);
        add_fetch(13, 32'h0000_3a50, 4'd13, 0, 0);
        add_fetch(14, 32'h0000_1000, 4'd14, 2, 0);
        add_fetch(15, 32'h0000_100c, 4'd15, 0, 0);
        // High tag on index 0x25
        add_fetch(16, 32'h8000_3a5c, 4'd0, 0, 1);
        add_fetch(17, 32'h0000_3a50, 4'd3, 3, 1);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Clock, memory model and watchdog
    ////////////////////////////////////////////////////////////////////////////

    initial begin : clock_gen
        aclk = 1'b0;
        forever #HALF_PERIOD aclk = ~aclk;
    end

    // Decisions at the falling edge take effect at the next rising edge
    initial begin : memory_model
        seed        = 32'hef3d;
        mem_arready = 1'b0;
        mem_rvalid  = 1'b0;
        mem_rdata   = '0;
        mem_rlast   = 1'b0;
        burst_count = 0;
        ar_fire     = 1'b0;
        r_fire      = 1'b0;
        r_active    = 1'b0;
        r_beat      = 0;
        r_base      = '0;
        forever begin
            @(negedge aclk);
            if (!rst_n) begin
                mem_arready = 1'b0;
                mem_rvalid  = 1'b0;
                mem_rlast   = 1'b0;
                ar_fire     = 1'b0;
                r_fire      = 1'b0;
                r_active    = 1'b0;
            end else begin
                // Handshakes completed at the last rising edge
                if (r_fire) begin
                    r_beat = r_beat + 1;
                    if (r_beat == `ICACHE_BEATS) begin
                        r_active = 1'b0;
                    end
                end
                if (ar_fire) begin
                    burst_count = burst_count + 1;
                    r_active    = 1'b1;
                    r_beat      = 0;
                end
                if (r_active) begin
                    check_count("mem_rready during burst", 1, int'(mem_rready));
                end
                // Next beat or a gap; a shown beat stays until taken
                if (r_active && (!mem_rvalid || r_fire)) begin
                    mem_rvalid = (($random(seed) & 3) != 0);
                    mem_rdata  = memory_word(r_base + addr_t'(r_beat * 4));
                    mem_rlast  = (r_beat == `ICACHE_BEATS - 1);
                end else if (!r_active) begin
                    mem_rvalid = 1'b0;
                    mem_rlast  = 1'b0;
                end
                // Address channel with random ready delay
                mem_arready = mem_arvalid && (($random(seed) & 1) == 0);
                if (mem_arvalid && mem_arready) begin
                    check_addr("burst address", cur_addr & ~addr_t'(15), mem_araddr);
                    check_len("burst length", 8'd3, mem_arlen);
                    r_base = mem_araddr;
                end
                ar_fire = mem_arvalid && mem_arready;
                r_fire  = mem_rvalid && mem_rready;
            end
        end
    end

    initial begin : watchdog
        repeat (NUM_TESTS * 200 + RESET_CYCLES) @(posedge aclk);
        stop_on_error("Watchdog: the tests did not finish in the allowed number of cycles");
    end

    ////////////////////////////////////////////////////////////////////////////
    // Table operations
    ////////////////////////////////////////////////////////////////////////////

    task automatic run_fetch(input int idx);
        string name;
        int    cycles;
        int    bursts_before;
        id_t   held_id;
        word_t held_word;
        name          = $sformatf("entry %0d fetch %h", idx, tests[idx].addr);
        bursts_before = burst_count;
        cur_addr      = tests[idx].addr;
        ctrl_arvalid  = 1'b1;
        ctrl_araddr   = tests[idx].addr;
        ctrl_arid     = tests[idx].id;
        while (!ctrl_arready) begin
            @(negedge aclk);
        end
        @(negedge aclk);
        ctrl_arvalid = 1'b0;
        // Rising edges from acceptance to the first response cycle
        cycles = 0;
        while (!ctrl_rvalid) begin
            @(negedge aclk);
            cycles = cycles + 1;
        end
        held_id   = ctrl_rid;
        held_word = ctrl_rdata;
        repeat (tests[idx].stall) begin
            @(negedge aclk);
            check_count({name, " rvalid held"}, 1, int'(ctrl_rvalid));
            check_id({name, " rid held"}, held_id, ctrl_rid);
            check_word({name, " rdata held"}, held_word, ctrl_rdata);
        end
        check_word({name, " rdata"}, tests[idx].exp_word, ctrl_rdata);
        check_id({name, " rid"}, tests[idx].id, ctrl_rid);
        ctrl_rready = 1'b1;
        @(negedge aclk);
        ctrl_rready = 1'b0;
        check_count({name, " rvalid after transfer"}, 0, int'(ctrl_rvalid));
        check_count({name, " bursts"}, bursts_before + tests[idx].exp_bursts, burst_count);
        if (tests[idx].exp_bursts == 0) begin
            check_count({name, " hit latency"}, 2, cycles);
        end
    endtask

    task automatic run_flush(input int idx);
        string name;
        int    cycles;
        int    bursts_before;
        name          = $sformatf("entry %0d flush", idx);
        bursts_before = burst_count;
        flush_req     = 1'b1;
        @(negedge aclk);
        cycles = 0;
        while (!flush_ack) begin
            @(negedge aclk);
            cycles = cycles + 1;
        end
        check_count({name, " ack latency"}, 2, cycles);
        flush_req = 1'b0;
        @(negedge aclk);
        // Single-cycle acknowledge
        check_count({name, " ack width"}, 0, int'(flush_ack));
        check_count({name, " bursts"}, bursts_before, burst_count);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin : stimulus
        rst_n        = 1'b0;
        flush_req    = 1'b0;
        ctrl_arvalid = 1'b0;
        ctrl_araddr  = '0;
        ctrl_arid    = '0;
        ctrl_rready  = 1'b0;
        cur_addr     = '0;
        load_table();
        // Reset spans whole clock cycles and is released on a falling edge
        repeat (RESET_CYCLES) @(posedge aclk);
        @(negedge aclk);
        rst_n = 1'b1;
        // Outputs right after reset
        check_count("arready at reset release", 0, int'(ctrl_arready));
        check_count("rvalid after reset", 0, int'(ctrl_rvalid));
        check_count("mem_arvalid after reset", 0, int'(mem_arvalid));
        check_count("mem_rready after reset", 0, int'(mem_rready));
        check_count("flush_ack after reset", 0, int'(flush_ack));
        @(negedge aclk);
        check_count("arready one cycle after reset", 1, int'(ctrl_arready));
        for (int i = 0; i < NUM_TESTS; i++) begin
            if (tests[i].is_flush) begin
                run_flush(i);
            end else begin
                run_fetch(i);
            end
        end
        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire
